/* files.f */
tracker_pkg.sv
sample_bank.sv
readout_port.sv
sample_ctrl.sv
line_tracker_top.sv
line_tracker_chk.sv
tb_line_tracker.sv

/* line_tracker_chk.sv */
`timescale 1ns/1ps

module line_tracker_chk (
	input logic                            clock_i,
	input logic                            resetn_i,
	input tracker_pkg::bank_port_t         bank_i,
	input logic                            stall_i,
	input logic [tracker_pkg::BW_BUFFER:0] count_i,
	input logic                            capture_i
);
	import tracker_pkg::*;

	// failed assertions so far
	int unsigned fail_cnt = 0;

	// ------------------------------------------------------------
	// write and fill checks
	// ------------------------------------------------------------

	// no write once stalled
	assert property (@(posedge clock_i) disable iff (!resetn_i) stall_i |=> !bank_i.wr)
	else begin
		$error("write strobe after stall");
		fail_cnt++;
	end

	// fill level bounded by the buffer depth
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		count_i <= (BW_BUFFER + 1)'(BUFFER_LIMIT))
	else begin
		$error("count beyond buffer depth");
		fail_cnt++;
	end

	// write only one cycle after a capture
	assert property (@(posedge clock_i) disable iff (!resetn_i) bank_i.wr |-> $past(capture_i))
	else begin
		$error("write strobe without capture");
		fail_cnt++;
	end

endmodule

bind sample_ctrl line_tracker_chk line_tracker_chk_i (
	.clock_i   (clock_i),
	.resetn_i  (resetn_i),
	.bank_i    (bank_o),
	.stall_i   (stall_o),
	.count_i   (count_o),
	.capture_i (capture)
);

/* line_tracker_top.sv */
`timescale 1ns/1ps

module line_tracker_top (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  tracker_pkg::tracker_cfg_t       cfg_i,
	input  logic                            request_i,
	input  logic                            en_i,
	input  tracker_pkg::expired_t           expired_bits_i,
	output logic                            stall_o,
	output logic [tracker_pkg::BW_BUFFER:0] count_o,
	output tracker_pkg::sample_t            trace_o
);
	import tracker_pkg::*;

	bank_port_t                      bank_port;
	sample_t                         wdata;
	logic [N_BANKS-1:0][N_LINES-1:0] bank_rdata;

	// ------------------------------------------------------------
	// controller
	// ------------------------------------------------------------

	sample_ctrl sample_ctrl_i (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.cfg_i          (cfg_i),
		.request_i      (request_i),
		.en_i           (en_i),
		.expired_bits_i (expired_bits_i),
		.bank_o         (bank_port),
		.wdata_o        (wdata),
		.stall_o        (stall_o),
		.count_o        (count_o)
	);

	// ------------------------------------------------------------
	// buffer banks
	// ------------------------------------------------------------

	for (genvar k = 0; k < N_BANKS; k++) begin : g_bank
		logic [N_LINES-1:0] bank_wdata;

		// bank 0 is the trace count, the rest the expired words
		if (k == 0) begin : g_trace
			assign bank_wdata = wdata.trace;
		end else begin : g_expired
			assign bank_wdata = wdata.expired[k-1];
		end

		sample_bank sample_bank_i (
			.clock_i (clock_i),
			.wr_i    (bank_port.wr),
			.addr_i  (bank_port.addr),
			.data_i  (bank_wdata),
			.data_o  (bank_rdata[k])
		);
	end

	// host readout
	readout_port readout_port_i (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.bank_data_i (bank_rdata),
		.trace_o     (trace_o)
	);

endmodule

/* readout_port.sv */
`timescale 1ns/1ps

module readout_port (
	input  logic                                                     clock_i,
	input  logic                                                     resetn_i,
	input  logic [tracker_pkg::N_BANKS-1:0][tracker_pkg::N_LINES-1:0] bank_data_i,
	output tracker_pkg::sample_t                                     trace_o
);
	import tracker_pkg::*;

	sample_t sample_d;

	// ------------------------------------------------------------
	// bank to sample mapping
	// ------------------------------------------------------------

	always_comb begin
		// bank 0 carries the trace count
		sample_d.trace = bank_data_i[0];
		// banks 1..3 carry expired words 0..2
		for (int k = 1; k < N_BANKS; k++) begin
			sample_d.expired[k-1] = bank_data_i[k];
		end
	end

	// ------------------------------------------------------------
	// host side register
	// ------------------------------------------------------------

	// second read stage, sample visible two cycles after rd_addr
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			trace_o <= '0;
		end else begin
			trace_o <= sample_d;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the line tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module tb_line_tracker

# keep the log even when the simulation exits with an error
./obj_dir/Vtb_line_tracker > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* sample_bank.sv */
`timescale 1ns/1ps

module sample_bank (
	input  logic                              clock_i,
	input  logic                              wr_i,
	input  logic [tracker_pkg::BW_BUFFER-1:0] addr_i,
	input  logic [tracker_pkg::N_LINES-1:0]   data_i,
	output logic [tracker_pkg::N_LINES-1:0]   data_o
);
	import tracker_pkg::*;

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	// one word per stored sample
	logic [N_LINES-1:0] mem_q [BUFFER_LIMIT];

	// single port, write and registered read share addr_i
	always_ff @(posedge clock_i) begin
		if (wr_i) begin
			mem_q[addr_i] <= data_i;
		end
	end

	// read returns the old word on a write cycle
	// readout only cares about non-write cycles
	always_ff @(posedge clock_i) begin
		data_o <= mem_q[addr_i];
	end

endmodule

/* sample_ctrl.sv */
`timescale 1ns/1ps

module sample_ctrl (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  tracker_pkg::tracker_cfg_t       cfg_i,
	input  logic                            request_i,
	input  logic                            en_i,
	input  tracker_pkg::expired_t           expired_bits_i,
	output tracker_pkg::bank_port_t         bank_o,
	output tracker_pkg::sample_t            wdata_o,
	output logic                            stall_o,
	output logic [tracker_pkg::BW_BUFFER:0] count_o
);
	import tracker_pkg::*;

	tracker_state_e       state_q;
	tracker_state_e       state_d;
	logic [N_LINES-1:0]   trace_cnt_q;
	logic [BW_PERIOD-1:0] samp_cnt_q;
	logic [BW_BUFFER:0]   count_q;
	logic                 wr_q;
	sample_t              capture_q;
	logic                 count_req;
	logic                 capture;
	logic                 last_wr;

	// ------------------------------------------------------------
	// request counting and capture
	// ------------------------------------------------------------

	// only counted while tracking and not stalled
	assign count_req = (state_q == ST_TRACK) && en_i && request_i;
	// this request takes the sampling counter to zero
	assign capture = count_req && (samp_cnt_q == BW_PERIOD'(1));
	// the write that fills the last free slot
	assign last_wr = wr_q && (count_q == (BW_BUFFER + 1)'(BUFFER_LIMIT - 1));

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			trace_cnt_q <= '0;
			samp_cnt_q <= BW_PERIOD'(SAMPLE_PERIOD);
		end else begin
			// trace count runs on across a clear
			if (count_req) begin
				trace_cnt_q <= trace_cnt_q + N_LINES'(1);
			end
			if (cfg_i.clear || capture) begin
				samp_cnt_q <= BW_PERIOD'(SAMPLE_PERIOD);
			end else if (count_req) begin
				samp_cnt_q <= samp_cnt_q - BW_PERIOD'(1);
			end
		end
	end

	// sample payload, count includes the capturing request
	always_ff @(posedge clock_i) begin
		if (capture) begin
			capture_q.trace <= trace_cnt_q + N_LINES'(1);
			capture_q.expired <= expired_bits_i;
		end
	end

	// ------------------------------------------------------------
	// write strobe, fill level and stall
	// ------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		if (cfg_i.clear) begin
			state_d = cfg_i.enable ? ST_TRACK : ST_IDLE;
		end else if (last_wr) begin
			state_d = ST_FULL;
		end else begin
			case (state_q)
				ST_IDLE: if (cfg_i.enable) state_d = ST_TRACK;
				ST_TRACK: if (!cfg_i.enable) state_d = ST_IDLE;
				// full holds until the host clears
				default: state_d = state_q;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= ST_IDLE;
			wr_q <= 1'b0;
			count_q <= '0;
		end else begin
			state_q <= state_d;
			// write lands one cycle after capture
			wr_q <= capture;
			if (cfg_i.clear) begin
				count_q <= '0;
			end else if (wr_q) begin
				count_q <= count_q + (BW_BUFFER + 1)'(1);
			end
		end
	end

	// write slot is the fill level before the increment
	// host address owns the banks in every other cycle
	assign bank_o.wr = wr_q;
	assign bank_o.addr = wr_q ? count_q[BW_BUFFER-1:0] : cfg_i.rd_addr;
	assign wdata_o = capture_q;
	assign stall_o = (state_q == ST_FULL);
	assign count_o = count_q;

endmodule

/* tb_line_tracker.sv */
`timescale 1ns/1ps

module tb_line_tracker;
	import tracker_pkg::*;

	logic               clock_i;
	logic               resetn_i;
	tracker_cfg_t       cfg_i;
	logic               request_i;
	logic               en_i;
	expired_t           expired_bits_i;
	logic               stall_o;
	logic [BW_BUFFER:0] count_o;
	sample_t            trace_o;

	// reference model of the tracker
	sample_t        m_mem [BUFFER_LIMIT];
	sample_t        m_capture;
	tracker_state_e m_state;
	int             m_trace;
	int             m_samp;
	int             m_count;
	logic           m_pending;

	// last values handed to the DUT inputs
	tracker_cfg_t   drv_cfg;
	logic           drv_en;

	line_tracker_top line_tracker_top_i (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.cfg_i          (cfg_i),
		.request_i      (request_i),
		.en_i           (en_i),
		.expired_bits_i (expired_bits_i),
		.stall_o        (stall_o),
		.count_o        (count_o),
		.trace_o        (trace_o)
	);

	// 100 ns period
	always #50 clock_i = ~clock_i;

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic compare_sample(input string name, input sample_t expected,
			input sample_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			$display("tests failed");
			$fatal(1, "sample mismatch");
		end
	endtask

	task automatic compare_count(input string name, input logic [BW_BUFFER:0] expected,
			input logic [BW_BUFFER:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("tests failed");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			$display("tests failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	// ------------------------------------------------------------
	// model and stimulus
	// ------------------------------------------------------------

	function automatic tracker_cfg_t make_cfg(input logic enable, input logic clear,
			input logic [BW_BUFFER-1:0] rd_addr);
		tracker_cfg_t cfg;
		cfg.enable = enable;
		cfg.clear = clear;
		cfg.rd_addr = rd_addr;
		return cfg;
	endfunction

	function automatic expired_t rand_expired();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[N_EXP_BANKS*N_LINES-1:0];
	endfunction

	// one model clock edge on the inputs the DUT samples there
	task automatic model_edge();
		logic counted;
		logic capture;
		counted = (m_state == ST_TRACK) && en_i && request_i;
		capture = counted && (m_samp == 1);
		if (!resetn_i) begin
			m_state = ST_IDLE;
			m_trace = 0;
			m_samp = SAMPLE_PERIOD;
			m_count = 0;
			m_pending = 1'b0;
		end else begin
			// pending write lands at the current fill level
			if (m_pending) begin
				m_mem[m_count] = m_capture;
			end
			if (cfg_i.clear) begin
				m_state = cfg_i.enable ? ST_TRACK : ST_IDLE;
			end else if (m_pending && (m_count == BUFFER_LIMIT - 1)) begin
				m_state = ST_FULL;
			end else if (m_state != ST_FULL) begin
				m_state = cfg_i.enable ? ST_TRACK : ST_IDLE;
			end
			if (cfg_i.clear) begin
				m_count = 0;
			end else if (m_pending) begin
				m_count++;
			end
			// capture holds the count including this request
			if (capture) begin
				m_capture.trace = N_LINES'(m_trace + 1);
				m_capture.expired = expired_bits_i;
			end
			if (counted) begin
				m_trace++;
			end
			if (cfg_i.clear || capture) begin
				m_samp = SAMPLE_PERIOD;
			end else if (counted) begin
				m_samp--;
			end
			m_pending = capture;
		end
	endtask

	// advance one edge and drive the next inputs
	task automatic tick(input tracker_cfg_t cfg, input logic req, input logic en,
			input expired_t bits);
		@(posedge clock_i);
		model_edge();
		cfg_i <= cfg;
		request_i <= req;
		en_i <= en;
		expired_bits_i <= bits;
		drv_cfg = cfg;
		drv_en = en;
	endtask

	// quiet cycles that flush a pending write
	task automatic hold(input int n);
		repeat (n) tick(make_cfg(drv_cfg.enable, 1'b0, drv_cfg.rd_addr), 1'b0, drv_en, '0);
	endtask

	task automatic reset_dut();
		repeat (5) tick(make_cfg(1'b0, 1'b0, '0), 1'b0, 1'b0, '0);
		resetn_i <= 1'b1;
	endtask

	// present rd_addr and compare two cycles later
	task automatic read_sample(input int addr, input sample_t expected);
		tracker_cfg_t cfg;
		cfg = make_cfg(drv_cfg.enable, 1'b0, BW_BUFFER'(addr));
		repeat (3) tick(cfg, 1'b0, drv_en, '0);
		@(negedge clock_i);
		compare_sample($sformatf("trace_o @ %0d", addr), expected, trace_o);
	endtask

	// random gap before each request with fresh expired bits
	task automatic request_burst(input int n);
		int gap;
		for (int i = 0; i < n; i++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) tick(make_cfg(1'b1, 1'b0, '0), 1'b0, 1'b1, rand_expired());
			tick(make_cfg(1'b1, 1'b0, '0), 1'b1, 1'b1, rand_expired());
		end
	endtask

	task automatic wait_for_stall(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clock_i);
		while (!stall_o) begin
			if (cycles == limit) begin
				$display("timeout: stall_o still low after %0d cycles", limit);
				$display("tests failed");
				$fatal(1, "stall wait timed out");
			end else begin
				tick(make_cfg(1'b1, 1'b0, '0), 1'b1, 1'b1, rand_expired());
				@(negedge clock_i);
				cycles++;
			end
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic test_reset();
		@(negedge clock_i);
		compare_bit("stall_o", 1'b0, stall_o);
		compare_count("count_o", '0, count_o);
		compare_sample("trace_o", '0, trace_o);
	endtask

	task automatic test_sampling();
		sample_t exp_s;
		// one idle cycle so the FSM is tracking before the first request
		tick(make_cfg(1'b1, 1'b0, '0), 1'b0, 1'b1, '0);
		request_burst(3 * SAMPLE_PERIOD);
		tick(make_cfg(1'b0, 1'b0, '0), 1'b0, 1'b1, '0);
		hold(2);
		@(negedge clock_i);
		compare_count("count_o", (BW_BUFFER + 1)'(3), count_o);
		for (int k = 0; k < 3; k++) begin
			exp_s = m_mem[k];
			exp_s.trace = N_LINES'((k + 1) * SAMPLE_PERIOD);
			read_sample(k, exp_s);
		end
	endtask

	task automatic test_gating();
		sample_t exp_s;
		// en_i low while tracking
		tick(make_cfg(1'b1, 1'b0, '0), 1'b0, 1'b0, '0);
		repeat (5) tick(make_cfg(1'b1, 1'b0, '0), 1'b1, 1'b0, rand_expired());
		// enable low
		tick(make_cfg(1'b0, 1'b0, '0), 1'b0, 1'b1, '0);
		repeat (5) tick(make_cfg(1'b0, 1'b0, '0), 1'b1, 1'b1, rand_expired());
		tick(make_cfg(1'b0, 1'b0, '0), 1'b0, 1'b1, '0);
		hold(2);
		@(negedge clock_i);
		compare_count("count_o", (BW_BUFFER + 1)'(3), count_o);
		// next sample still lands on the ungated count
		tick(make_cfg(1'b1, 1'b0, '0), 1'b0, 1'b1, '0);
		request_burst(SAMPLE_PERIOD);
		hold(2);
		@(negedge clock_i);
		compare_count("count_o", (BW_BUFFER + 1)'(4), count_o);
		exp_s = m_mem[3];
		exp_s.trace = N_LINES'(4 * SAMPLE_PERIOD);
		read_sample(3, exp_s);
	endtask

	task automatic test_full();
		sample_t exp_s;
		wait_for_stall(200);
		compare_count("count_o", (BW_BUFFER + 1)'(BUFFER_LIMIT), count_o);
		// requests while stalled are dropped
		repeat (6) tick(make_cfg(1'b1, 1'b0, '0), 1'b1, 1'b1, rand_expired());
		hold(2);
		@(negedge clock_i);
		compare_bit("stall_o", 1'b1, stall_o);
		compare_count("count_o", (BW_BUFFER + 1)'(BUFFER_LIMIT), count_o);
		for (int k = 0; k < BUFFER_LIMIT; k++) begin
			exp_s = m_mem[k];
			exp_s.trace = N_LINES'((k + 1) * SAMPLE_PERIOD);
			read_sample(k, exp_s);
		end
	endtask

	task automatic test_clear();
		int trace_before;
		sample_t exp_s;
		tick(make_cfg(1'b1, 1'b1, '0), 1'b0, 1'b1, '0);
		tick(make_cfg(1'b1, 1'b0, '0), 1'b0, 1'b1, '0);
		@(negedge clock_i);
		compare_bit("stall_o", 1'b0, stall_o);
		compare_count("count_o", '0, count_o);
		// trace counter is not cleared
		trace_before = m_trace;
		request_burst(2 * SAMPLE_PERIOD);
		hold(2);
		@(negedge clock_i);
		compare_count("count_o", (BW_BUFFER + 1)'(2), count_o);
		for (int k = 0; k < 2; k++) begin
			exp_s = m_mem[k];
			exp_s.trace = N_LINES'(trace_before + (k + 1) * SAMPLE_PERIOD);
			read_sample(k, exp_s);
		end
	endtask

	initial begin
		clock_i = 1'b0;
		resetn_i = 1'b0;
		cfg_i = '0;
		request_i = 1'b0;
		en_i = 1'b0;
		expired_bits_i = '0;
		drv_cfg = '0;
		drv_en = 1'b0;
		void'($urandom(32'h7cd8_5e3f));
		reset_dut();
		test_reset();
		test_sampling();
		test_gating();
		test_full();
		test_clear();
		hold(2);
		if (line_tracker_top_i.sample_ctrl_i.line_tracker_chk_i.fail_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* tracker_pkg.sv */
package tracker_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------

	// cache lines per expired-bit bank, also the bank word width
	localparam int N_LINES = 16;
	// expired-bit banks
	localparam int N_EXP_BANKS = 3;
	// trace bank plus expired-bit banks
	localparam int N_BANKS = N_EXP_BANKS + 1;
	// counted requests per stored sample
	localparam int SAMPLE_PERIOD = 4;
	// buffer depth in samples
	localparam int BUFFER_LIMIT = 8;
	localparam int BW_BUFFER = $clog2(BUFFER_LIMIT);
	// sampling counter width, must hold SAMPLE_PERIOD itself
	localparam int BW_PERIOD = $clog2(SAMPLE_PERIOD + 1);

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_TRACK = 2'd1,
		ST_FULL  = 2'd2
	} tracker_state_e;

	// host configuration word
	typedef struct packed {
		logic                 enable;
		logic                 clear;
		logic [BW_BUFFER-1:0] rd_addr;
	} tracker_cfg_t;

	// expired bits of all banks, word k is bank k+1
	typedef logic [N_EXP_BANKS-1:0][N_LINES-1:0] expired_t;

	// one stored sample
	typedef struct packed {
		logic [N_LINES-1:0] trace;
		expired_t           expired;
	} sample_t;

	// shared access to all banks
	typedef struct packed {
		logic                 wr;
		logic [BW_BUFFER-1:0] addr;
	} bank_port_t;

endpackage
